/* hw/cpuPkg.sv */
package cpuPkg;

  // ---------------------------------------------------------------------------
  // Micro-op encoding
  // ---------------------------------------------------------------------------
  typedef enum logic [3:0]
  {
    nop        = 4'd0,
    setAddrPc  = 4'd1,
    setAddrHl  = 4'd2,
    jumpDecode = 4'd3,
    loadMem    = 4'd4,
    moveReg    = 4'd5,
    aluOp      = 4'd6,
    writeMem   = 4'd7,
    setIe      = 4'd8,
    clearIe    = 4'd9,
    jumpInt    = 4'd10
  } uopCmd_e;

  // Z80 register field codes, 6 is the (HL) operand
  typedef enum logic [2:0]
  {
    regB   = 3'd0,
    regC   = 3'd1,
    regD   = 3'd2,
    regE   = 3'd3,
    regH   = 3'd4,
    regL   = 3'd5,
    regMem = 3'd6,
    regA   = 3'd7
  } regCode_e;

  typedef struct packed
  {
    logic     incPc;
    logic     endFlow;   // Last uop of the flow
    uopCmd_e  cmd;
    regCode_e operand;   // regMem means take the field from the opcode
  } uop_t;

  typedef struct packed
  {
    logic [15:0] addr;
    logic [7:0]  wrData;
    logic        we;
    logic        readReq;
  } memBus_t;

  typedef logic [5:0] flowIdx_t;

  // Flow entry points in the microcode table
  localparam flowIdx_t flowFetch = 6'd0;
  localparam flowIdx_t flowLdImm = 6'd3;
  localparam flowIdx_t flowLdReg = 6'd6;
  localparam flowIdx_t flowAlu   = 6'd7;
  localparam flowIdx_t flowStore = 6'd8;
  localparam flowIdx_t flowEi    = 6'd9;
  localparam flowIdx_t flowDi    = 6'd10;
  localparam flowIdx_t flowNop   = 6'd11;
  localparam flowIdx_t flowInt   = 6'd12;

  // Interrupt vectors, request bit 0 first
  localparam logic [3:0][15:0] intVec = {16'h0060, 16'h0050, 16'h0048, 16'h0040};

  localparam logic [15:0] resetPcDefault = 16'h0000;

endpackage

/* hw/microcodeRom.sv */
`timescale 1ns/1ps

module microcodeRom
(
  input  cpuPkg::flowIdx_t upc,
  output cpuPkg::uop_t     uop
);

  function automatic cpuPkg::uop_t mkUop(input logic inc, input logic eof,
                                         input cpuPkg::uopCmd_e cmd,
                                         input cpuPkg::regCode_e operand);
    cpuPkg::uop_t u;
    u.incPc   = inc;
    u.endFlow = eof;
    u.cmd     = cmd;
    u.operand = operand;
    return u;
  endfunction

  always_comb
  begin
    case (upc)
      // Fetch
      cpuPkg::flowFetch:         uop = mkUop(1'b1, 1'b0, cpuPkg::setAddrPc, cpuPkg::regMem);
      cpuPkg::flowFetch + 6'd1:  uop = mkUop(1'b0, 1'b0, cpuPkg::nop, cpuPkg::regMem);
      cpuPkg::flowFetch + 6'd2:  uop = mkUop(1'b0, 1'b0, cpuPkg::jumpDecode, cpuPkg::regMem);
      // LD r,d8
      cpuPkg::flowLdImm:         uop = mkUop(1'b1, 1'b0, cpuPkg::setAddrPc, cpuPkg::regMem);
      cpuPkg::flowLdImm + 6'd1:  uop = mkUop(1'b0, 1'b0, cpuPkg::nop, cpuPkg::regMem);
      cpuPkg::flowLdImm + 6'd2:  uop = mkUop(1'b0, 1'b1, cpuPkg::loadMem, cpuPkg::regMem);
      cpuPkg::flowLdReg:         uop = mkUop(1'b0, 1'b1, cpuPkg::moveReg, cpuPkg::regMem);
      cpuPkg::flowAlu:           uop = mkUop(1'b0, 1'b1, cpuPkg::aluOp, cpuPkg::regA);
      cpuPkg::flowStore:         uop = mkUop(1'b0, 1'b1, cpuPkg::writeMem, cpuPkg::regMem);
      cpuPkg::flowEi:            uop = mkUop(1'b0, 1'b1, cpuPkg::setIe, cpuPkg::regMem);
      cpuPkg::flowDi:            uop = mkUop(1'b0, 1'b1, cpuPkg::clearIe, cpuPkg::regMem);
      cpuPkg::flowNop:           uop = mkUop(1'b0, 1'b1, cpuPkg::nop, cpuPkg::regMem);
      cpuPkg::flowInt:           uop = mkUop(1'b0, 1'b1, cpuPkg::jumpInt, cpuPkg::regMem);
      default:                   uop = mkUop(1'b0, 1'b1, cpuPkg::nop, cpuPkg::regMem);
    endcase
  end

endmodule

/* hw/flowDispatch.sv */
`timescale 1ns/1ps

module flowDispatch
(
  input  logic             iClock,
  input  logic             rstN,
  input  logic [7:0]       memRdData,
  input  logic [3:0]       intReq,
  input  cpuPkg::uop_t     uop,
  input  logic             flowRun,
  output cpuPkg::flowIdx_t nextFlow,
  output logic [7:0]       opcode,
  output logic [15:0]      vector
);

  cpuPkg::flowIdx_t decodedFlow;
  logic [3:0]       intLatch;
  logic             intEnable;
  logic             takeInt;

  // Opcode arrives on the read data in the jumpDecode cycle
  always_ff @(posedge iClock)
  begin
    if (flowRun && uop.cmd == cpuPkg::jumpDecode)
      opcode <= memRdData;
  end

  // --------------------------------------------------------------------------
  // Opcode to flow lookup
  // --------------------------------------------------------------------------
  always_comb
  begin
    decodedFlow = cpuPkg::flowNop;
    case (memRdData[7:6])
      2'b00:
      begin
        if (memRdData[2:0] == cpuPkg::regMem && memRdData[5:3] != cpuPkg::regMem)
          decodedFlow = cpuPkg::flowLdImm;             // LD r,d8
      end
      2'b01:
      begin
        if (memRdData[2:0] != cpuPkg::regMem)
        begin
          if (memRdData[5:3] == cpuPkg::regMem)
            decodedFlow = cpuPkg::flowStore;            // LD (HL),r
          else
            decodedFlow = cpuPkg::flowLdReg;
        end
      end
      2'b10:
      begin
        if (memRdData[5:3] inside {3'd4, 3'd5, 3'd6} && memRdData[2:0] != cpuPkg::regMem)
          decodedFlow = cpuPkg::flowAlu;                // AND, XOR, OR
      end
      default:
      begin
        if (memRdData == 8'hFB)
          decodedFlow = cpuPkg::flowEi;
        else if (memRdData == 8'hF3)
          decodedFlow = cpuPkg::flowDi;
      end
    endcase
  end

  assign takeInt  = intEnable && (intLatch != 4'b0);
  assign nextFlow = takeInt ? cpuPkg::flowInt : decodedFlow;

  // Requests stay latched until the jump is taken
  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      intLatch  <= 4'b0;
      intEnable <= 1'b0;
    end
    else if (flowRun && uop.cmd == cpuPkg::jumpInt)
    begin
      intLatch  <= 4'b0;
      intEnable <= 1'b0;
    end
    else
    begin
      intLatch <= intLatch | intReq;
      if (flowRun && uop.cmd == cpuPkg::setIe)
        intEnable <= 1'b1;
      else if (flowRun && uop.cmd == cpuPkg::clearIe)
        intEnable <= 1'b0;
    end
  end

  // Lowest request bit wins
  always_comb
  begin
    vector = cpuPkg::intVec[0];
    for (int i = 3; i >= 0; i--)
    begin
      if (intLatch[i])
        vector = cpuPkg::intVec[i];
    end
  end

endmodule

/* hw/flowSequencer.sv */
`timescale 1ns/1ps

module flowSequencer
#(
  parameter logic [15:0] resetPc = cpuPkg::resetPcDefault
)
(
  input  logic             iClock,
  input  logic             rstN,
  input  cpuPkg::flowIdx_t nextFlow,
  input  logic [15:0]      vector,
  output cpuPkg::uop_t     uop,
  output logic             flowRun,
  output logic [15:0]      pc
);

  typedef enum logic [1:0] {stAfterReset, stStartFlow, stRun, stEndFlow} flowState_e;

  flowState_e       state;
  cpuPkg::flowIdx_t upc;

  microcodeRom rom_i
  (
    .upc (upc),
    .uop (uop)
  );

  assign flowRun = (state == stRun);

  // --------------------------------------------------------------------------
  // Flow state and micro program counter
  // --------------------------------------------------------------------------
  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      state <= stAfterReset;
      upc   <= cpuPkg::flowFetch;
    end
    else
    begin
      case (state)
        stAfterReset: state <= stStartFlow;
        stStartFlow:
        begin
          upc   <= cpuPkg::flowFetch;
          state <= stRun;
        end
        stRun:
        begin
          if (uop.cmd == cpuPkg::jumpDecode)
            upc <= nextFlow;
          else
            upc <= upc + 6'd1;
          if (uop.endFlow)
            state <= stEndFlow;
        end
        default: state <= stStartFlow;   // End of flow
      endcase
    end
  end

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
      pc <= resetPc;
    else if (flowRun && uop.cmd == cpuPkg::jumpInt)
      pc <= vector;
    else if (flowRun && uop.incPc)
      pc <= pc + 16'd1;
  end

endmodule

/* hw/uopExecute.sv */
`timescale 1ns/1ps

module uopExecute
(
  input  logic         iClock,
  input  logic         rstN,
  input  cpuPkg::uop_t uop,
  input  logic         flowRun,
  input  logic [7:0]   opcode,
  input  logic [7:0]   memRdData,
  output logic [15:0]  hl,
  output logic [7:0]   storeData
);

  // Indexed by register code, slot 6 is never written
  logic [7:0]       regFile [8];
  cpuPkg::regCode_e dstCode;
  logic [7:0]       srcData;
  logic [7:0]       aluResult;
  logic [7:0]       wrValue;
  logic             wrEn;

  assign dstCode = (uop.operand == cpuPkg::regMem) ? cpuPkg::regCode_e'(opcode[5:3])
                                                   : uop.operand;
  assign srcData = regFile[opcode[2:0]];

  // --------------------------------------------------------------------------
  // ALU and write decode
  // --------------------------------------------------------------------------
  always_comb
  begin
    case (opcode[4:3])
      2'b00:   aluResult = regFile[cpuPkg::regA] & srcData;
      2'b01:   aluResult = regFile[cpuPkg::regA] ^ srcData;
      default: aluResult = regFile[cpuPkg::regA] | srcData;
    endcase
  end

  always_comb
  begin
    wrEn    = 1'b0;
    wrValue = srcData;
    case (uop.cmd)
      cpuPkg::loadMem:
      begin
        wrEn    = flowRun;
        wrValue = memRdData;                  // Immediate byte
      end
      cpuPkg::moveReg: wrEn = flowRun;
      cpuPkg::aluOp:
      begin
        wrEn    = flowRun;
        wrValue = aluResult;
      end
      default: wrEn = 1'b0;
    endcase
  end

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < 8; i++)
        regFile[i] <= 8'h00;
    end
    else if (wrEn && dstCode != cpuPkg::regMem)
    begin
      regFile[dstCode] <= wrValue;
    end
  end

  assign hl        = {regFile[cpuPkg::regH], regFile[cpuPkg::regL]};
  assign storeData = srcData;

endmodule

/* hw/busInterface.sv */
`timescale 1ns/1ps

module busInterface
(
  input  logic            iClock,
  input  logic            rstN,
  input  cpuPkg::uop_t    uop,
  input  logic            flowRun,
  input  logic [15:0]     pc,
  input  logic [15:0]     hl,
  input  logic [7:0]      storeData,
  output cpuPkg::memBus_t memBus
);

  logic [15:0] addrQ;
  logic [7:0]  wrDataQ;
  logic        weQ;
  logic        readReqQ;

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      addrQ    <= 16'h0000;
      weQ      <= 1'b0;
      readReqQ <= 1'b0;
    end
    else
    begin
      weQ      <= flowRun && uop.cmd == cpuPkg::writeMem;   // One cycle strobe
      readReqQ <= flowRun && uop.cmd == cpuPkg::setAddrPc;
      if (flowRun && uop.cmd == cpuPkg::setAddrPc)
        addrQ <= pc;
      else if (flowRun && (uop.cmd == cpuPkg::writeMem || uop.cmd == cpuPkg::setAddrHl))
        addrQ <= hl;
    end
  end

  always_ff @(posedge iClock)
  begin
    if (flowRun && uop.cmd == cpuPkg::writeMem)
      wrDataQ <= storeData;
  end

  always_comb
  begin
    memBus.addr    = addrQ;
    memBus.wrData  = wrDataQ;
    memBus.we      = weQ;
    memBus.readReq = readReqQ;
  end

endmodule

/* hw/gbCpuCore.sv */
`timescale 1ns/1ps

module gbCpuCore
#(
  parameter logic [15:0] resetPc = cpuPkg::resetPcDefault
)
(
  input  logic            iClock,
  input  logic            rstN,
  input  logic [7:0]      memRdData,
  input  logic [3:0]      intReq,
  output cpuPkg::memBus_t memBus
);

  cpuPkg::uop_t     uop;
  cpuPkg::flowIdx_t nextFlow;
  logic             flowRun;
  logic [7:0]       opcode;
  logic [15:0]      vector;
  logic [15:0]      pc;
  logic [15:0]      hl;
  logic [7:0]       storeData;

  flowDispatch dispatch_i
  (
    .iClock    (iClock),
    .rstN      (rstN),
    .memRdData (memRdData),
    .intReq    (intReq),
    .uop       (uop),
    .flowRun   (flowRun),
    .nextFlow  (nextFlow),
    .opcode    (opcode),
    .vector    (vector)
  );

  flowSequencer #(.resetPc(resetPc)) sequencer_i
  (
    .iClock   (iClock),
    .rstN     (rstN),
    .nextFlow (nextFlow),
    .vector   (vector),
    .uop      (uop),
    .flowRun  (flowRun),
    .pc       (pc)
  );

  uopExecute execute_i
  (
    .iClock    (iClock),
    .rstN      (rstN),
    .uop       (uop),
    .flowRun   (flowRun),
    .opcode    (opcode),
    .memRdData (memRdData),
    .hl        (hl),
    .storeData (storeData)
  );

  busInterface bus_i
  (
    .iClock    (iClock),
    .rstN      (rstN),
    .uop       (uop),
    .flowRun   (flowRun),
    .pc        (pc),
    .hl        (hl),
    .storeData (storeData),
    .memBus    (memBus)
  );

endmodule

/* dv/gbCpuTb.sv */
`timescale 1ns/1ps

module gbCpuTb;

  localparam logic [15:0] mainBase = 16'h0100;
  localparam logic [15:0] intBase  = 16'h0048;
  localparam logic [3:0]  reqBits  = 4'b0110;   // Bit 1 has priority over bit 2

  logic            iClock;
  logic            rstN;
  logic [7:0]      memRdData;
  logic [3:0]      intReq;
  cpuPkg::memBus_t memBus;

  logic [7:0]      mem [0:65535];
  logic [15:0]     fillPtr;
  logic [15:0]     mainEnd;
  logic [15:0]     vecEnd;
  logic [7:0]      hiByte;
  logic [15:0]     expFetches [$];
  cpuPkg::memBus_t expWrites [$];
  int              seed = 5591;
  int              progBytes = 0;
  int              cycleLimit = 200;
  int              cycleCount = 0;
  int              writesSeen = 0;
  int              expWriteCount;

  gbCpuCore #(.resetPc(16'h0100)) dut_i
  (
    .iClock    (iClock),
    .rstN      (rstN),
    .memRdData (memRdData),
    .intReq    (intReq),
    .memBus    (memBus)
  );

  always #2 iClock = ~iClock;

  // Memory with one cycle of read latency
  always @(posedge iClock)
  begin
    memRdData <= mem[memBus.addr];
    if (memBus.we)
      mem[memBus.addr] = memBus.wrData;
  end

  // --------------------------------------------------------------------------
  // Program building
  // --------------------------------------------------------------------------
  function automatic logic [7:0] randByte();
    int r;
    r = $random(seed);
    return r[7:0];
  endfunction

  task automatic placeByte(input logic [7:0] value);
    mem[fillPtr] = value;
    fillPtr      = fillPtr + 16'd1;
    progBytes++;
  endtask

  task automatic placeImm(input logic [7:0] op, input logic [7:0] value);
    placeByte(op);
    placeByte(value);
  endtask

  function automatic logic [15:0] lowestVector(input logic [3:0] req);
    if (req[0])
      return 16'h0040;
    else if (req[1])
      return 16'h0048;
    else if (req[2])
      return 16'h0050;
    else
      return 16'h0060;
  endfunction

  // Walks the code in memory and queues every fetch address and every write
  function automatic int predictTrace(input logic [15:0] startPc, input logic [3:0] pending);
    logic [7:0]      regs [8];
    logic [15:0]     pc;
    logic [7:0]      op;
    logic [2:0]      dst;
    logic [2:0]      src;
    logic            ie;
    int              steps;
    int              writes;
    cpuPkg::memBus_t w;
    regs   = '{default: 8'h00};
    pc     = startPc;
    ie     = 1'b0;
    steps  = 0;
    writes = 0;
    while (((pc >= mainBase && pc < mainEnd) || (pc >= intBase && pc < vecEnd)) && steps < 200)
    begin
      op  = mem[pc];
      dst = op[5:3];
      src = op[2:0];
      expFetches.push_back(pc);
      pc = pc + 16'd1;
      steps++;
      if (ie && pending != 4'b0000 && writes != 0)   // Requests rise after the first store
      begin
        pc = lowestVector(pending);   // Fetched opcode is dropped
        ie = 1'b0;
      end
      else if (op[7:6] == 2'b00 && src == 3'd6 && dst != 3'd6)
      begin
        expFetches.push_back(pc);
        regs[dst] = mem[pc];
        pc        = pc + 16'd1;
      end
      else if (op[7:6] == 2'b01 && src != 3'd6 && dst == 3'd6)
      begin
        w.addr    = {regs[3'd4], regs[3'd5]};
        w.wrData  = regs[src];
        w.we      = 1'b1;
        w.readReq = 1'b0;
        expWrites.push_back(w);
        writes++;
      end
      else if (op[7:6] == 2'b01 && src != 3'd6)
        regs[dst] = regs[src];
      else if (op[7:6] == 2'b10 && src != 3'd6 && dst == 3'd4)
        regs[3'd7] = regs[3'd7] & regs[src];
      else if (op[7:6] == 2'b10 && src != 3'd6 && dst == 3'd5)
        regs[3'd7] = regs[3'd7] ^ regs[src];
      else if (op[7:6] == 2'b10 && src != 3'd6 && dst == 3'd6)
        regs[3'd7] = regs[3'd7] | regs[src];
      else if (op == 8'hFB)
        ie = 1'b1;
      else if (op == 8'hF3)
        ie = 1'b0;
    end
    return writes;
  endfunction

  // --------------------------------------------------------------------------
  // Compare tasks and compare process
  // --------------------------------------------------------------------------
  task automatic checkFetch(input logic [15:0] addr);
    logic [15:0] expAddr;
    expAddr = expFetches.pop_front();
    if (addr !== expAddr)
    begin
      $display("CHECK FAILED at time %0t: fetch address %h, expected %h", $time, addr, expAddr);
      $display("** FAIL **");
      $fatal(1, "Fetch address mismatch");
    end
  endtask

  task automatic checkWrite(input cpuPkg::memBus_t got);
    cpuPkg::memBus_t expBus;
    if (expWrites.size() == 0)
    begin
      $display("Unexpected write of %h to %h at time %0t", got.wrData, got.addr, $time);
      $display("** FAIL **");
      $fatal(1, "Unexpected write");
    end
    else
    begin
      expBus = expWrites.pop_front();
      if (got !== expBus)
      begin
        $display("CHECK FAILED at time %0t: write %h <= %h, expected %h <= %h",
                 $time, got.addr, got.wrData, expBus.addr, expBus.wrData);
        $display("** FAIL **");
        $fatal(1, "Write mismatch");
      end
      else
        writesSeen++;
    end
  endtask

  always @(posedge iClock)
  begin
    if (rstN)
    begin
      if (memBus.readReq && memBus.we)
      begin
        $display("Read request and write strobe were high together at time %0t", $time);
        $display("** FAIL **");
        $fatal(1, "Bus conflict");
      end
      else
      begin
        if (memBus.readReq && expFetches.size() != 0)
          checkFetch(memBus.addr);
        if (memBus.we)
          checkWrite(memBus);
      end
    end
  end

  always @(posedge iClock)
  begin
    if (rstN)
    begin
      cycleCount = cycleCount + 1;
      if (cycleCount >= cycleLimit)
      begin
        $display("Run did not finish within %0d cycles", cycleLimit);
        $display("** FAIL **");
        $fatal(1, "Timeout");
      end
    end
  end

  initial
  begin
    iClock    = 1'b0;
    rstN      <= 1'b0;
    intReq    <= 4'b0000;
    memRdData <= 8'h00;
    for (int a = 0; a < 65536; a++)
      mem[a[15:0]] = 8'h00;

    fillPtr = mainBase;
    placeByte(8'hFB);                       // EI
    placeByte(8'hF3);                       // DI
    hiByte = randByte();
    placeImm(8'h26, {4'hC, hiByte[3:0]});   // LD H,d8 keeps stores away from code
    placeImm(8'h2E, randByte());            // LD L,d8
    placeImm(8'h06, randByte());            // LD B,d8
    placeByte(8'h70);                       // LD (HL),B
    placeImm(8'h0E, randByte());            // LD C,d8
    placeByte(8'h51);                       // LD D,C
    placeByte(8'h5A);                       // LD E,D
    placeByte(8'h7B);                       // LD A,E
    placeByte(8'h77);                       // LD (HL),A
    placeImm(8'h2E, randByte());
    placeImm(8'h3E, randByte());            // LD A,d8
    placeImm(8'h06, randByte());
    placeByte(8'hA0);                       // AND A,B
    placeImm(8'h0E, randByte());
    placeByte(8'hA9);                       // XOR A,C
    placeImm(8'h16, randByte());            // LD D,d8
    placeByte(8'hB2);                       // OR A,D
    placeByte(8'h77);
    // Opcodes that decode as NOP
    placeByte(8'h00);
    placeByte(8'h76);
    placeByte(8'hC3);
    placeByte(8'h86);
    placeByte(8'h27);
    placeByte(8'h73);                       // LD (HL),E
    placeByte(8'hFB);                       // EI
    placeByte(8'h00);                       // Replaced by the interrupt jump
    placeByte(8'h70);
    mainEnd = fillPtr;

    fillPtr = intBase;                      // Handler at the bit 1 vector
    placeImm(8'h2E, 8'h5A);
    placeImm(8'h3E, 8'hA5);
    placeByte(8'h77);                       // Marker store
    vecEnd = fillPtr;

    expWriteCount = predictTrace(mainBase, reqBits);
    cycleLimit    = 20 * progBytes + 200;

    repeat (8)
      @(posedge iClock);
    rstN <= 1'b1;

    // Requests arrive while DI is in effect
    while (writesSeen < 1)
      @(posedge iClock);
    intReq <= reqBits;

    while (expFetches.size() != 0 || expWrites.size() != 0)
      @(posedge iClock);
    repeat (20)
      @(posedge iClock);                    // Any stray write shows up here
    $display("%0d of %0d writes matched", writesSeen, expWriteCount);
    $display("** PASS **");
    $finish;
  end

endmodule

/* sources.f */
hw/cpuPkg.sv
hw/microcodeRom.sv
hw/flowDispatch.sv
hw/flowSequencer.sv
hw/uopExecute.sv
hw/busInterface.sv
hw/gbCpuCore.sv
dv/gbCpuTb.sv

/* run.sh */
#!/bin/sh
# Build and run the gbCpuCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module gbCpuTb -f sources.f -o gbCpuSim
if [ $? -ne 0 ]; then
  echo "Verilator build did not complete"
  exit 1
fi

./obj_dir/gbCpuSim > sim.log 2>&1
runStatus=$?
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $runStatus -ne 0 ]; then
  echo "Simulator exited with status $runStatus"
  exit 1
fi
echo "Simulation finished cleanly"
exit 0
